/* filelist.f */
src/xbar_pkg.sv
src/pipeline_ff.sv
src/xbar_route_decode.sv
src/xbar_priority_select.sv
src/crossbar.sv
src/xbar_stats_wb.sv
src/xbar_top.sv
sim/tb_clock_gen.sv
sim/tb_xbar_top.sv

/* Makefile */
TOP = tb_xbar_top

all: run

build:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing -sv -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* sim/tb_xbar_top.sv */
module tb_xbar_top;

	import xbar_pkg::*;

	localparam int ROUTE_W = DST_COUNT * (1 + SRC_IDX_WIDTH + DATA_WIDTH);

	typedef logic [SRC_COUNT-1:0] src_mask_t;
	typedef logic [DST_COUNT-1:0] dst_mask_t;

	logic                     clk;
	logic                     arst_n;
	logic                     cke;
	src_mask_t                in_valid;
	dst_idx_t [SRC_COUNT-1:0] in_dst_index;
	xb_data_t [SRC_COUNT-1:0] in_data;
	dst_mask_t                out_valid;
	src_idx_t [DST_COUNT-1:0] out_src_index;
	xb_data_t [DST_COUNT-1:0] out_data;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	wb_adr_t                  wb_adr;
	wb_dat_t                  wb_dat_w;
	wb_dat_t                  wb_dat_r;
	logic                     wb_ack;

	// model pipeline, entry 2 is what the outputs should show
	logic [ROUTE_W-1:0]       model [3];
	logic [2:0]               model_defined;
	cnt_t                     model_deliv [DST_COUNT];
	cnt_t                     model_offered;

	string test_name;
	int    test_errors;
	int    error_total;
	int    tests_run;
	int    tests_failed;

	tb_clock_gen clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	xbar_top #(
		.STAGE0_REG (1'b1),
		.STAGE1_REG (1'b1),
		.STAGE2_REG (1'b1)
	) xbar_top_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.cke           (cke),
		.in_valid      (in_valid),
		.in_dst_index  (in_dst_index),
		.in_data       (in_data),
		.out_valid     (out_valid),
		.out_src_index (out_src_index),
		.out_data      (out_data),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack)
	);

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// per destination, first valid source found from index 0 upward
	function automatic logic [ROUTE_W-1:0] expected_route(
		input src_mask_t                v,
		input dst_idx_t [SRC_COUNT-1:0] idx,
		input xb_data_t [SRC_COUNT-1:0] dat
	);
		dst_mask_t                ov;
		src_idx_t [DST_COUNT-1:0] os;
		xb_data_t [DST_COUNT-1:0] od;
		ov = '0;
		os = '0;
		od = '0;
		for (int d = 0; d < DST_COUNT; d++) begin
			for (int s = 0; s < SRC_COUNT; s++) begin
				if (!ov[d] && v[s] && idx[s] == dst_idx_t'(d)) begin
					ov[d] = 1'b1;
					os[d] = src_idx_t'(s);
					od[d] = dat[s];
				end
			end
		end
		return {ov, os, od};
	endfunction

	// shifts and counts only on enabled edges
	always @(posedge clk or negedge arst_n) begin
		dst_mask_t                exp_valid;
		src_idx_t [DST_COUNT-1:0] exp_src;
		xb_data_t [DST_COUNT-1:0] exp_data;
		if (!arst_n) begin
			model_defined = '0;
			model_offered = '0;
			for (int d = 0; d < DST_COUNT; d++) begin
				model_deliv[d] = '0;
			end
		end else if (cke) begin
			{exp_valid, exp_src, exp_data} = model[2];
			for (int d = 0; d < DST_COUNT; d++) begin
				if (model_defined[2] && exp_valid[d]) begin
					model_deliv[d] = model_deliv[d] + 1;
				end
			end
			model_offered = model_offered + cnt_t'($countones(in_valid));
			model[2] = model[1];
			model[1] = model[0];
			model[0] = expected_route(in_valid, in_dst_index, in_data);
			model_defined = {model_defined[1:0], 1'b1};
		end
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic note_error();
		error_total++;
		test_errors++;
	endtask

	task automatic check_valid(input dst_mask_t exp, input dst_mask_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s out_valid: expected %b actual %b", test_name, exp, act);
			note_error();
		end
	endtask

	task automatic check_src_index(input int lane, input src_idx_t exp, input src_idx_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s out_src_index[%0d]: expected %0d actual %0d",
				test_name, lane, exp, act);
			note_error();
		end
	endtask

	task automatic check_data(input int lane, input xb_data_t exp, input xb_data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s out_data[%0d]: expected %h actual %h",
				test_name, lane, exp, act);
			note_error();
		end
	endtask

	task automatic check_count(input string what, input cnt_t exp, input cnt_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
			note_error();
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		dst_mask_t                exp_valid;
		src_idx_t [DST_COUNT-1:0] exp_src;
		xb_data_t [DST_COUNT-1:0] exp_data;
		if (arst_n && model_defined[2]) begin
			{exp_valid, exp_src, exp_data} = model[2];
			check_valid(exp_valid, out_valid);
			for (int d = 0; d < DST_COUNT; d++) begin
				check_src_index(d, exp_src[d], out_src_index[d]);
				check_data(d, exp_data[d], out_data[d]);
			end
		end
	end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", test_name, test_errors);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	task automatic drive_cycle(
		input src_mask_t                v,
		input dst_idx_t [SRC_COUNT-1:0] idx,
		input xb_data_t [SRC_COUNT-1:0] dat,
		input logic                     en
	);
		@(negedge clk);
		in_valid = v;
		in_dst_index = idx;
		in_data = dat;
		cke = en;
	endtask

	task automatic random_cycle(input logic en);
		dst_idx_t [SRC_COUNT-1:0] idx;
		xb_data_t [SRC_COUNT-1:0] dat;
		for (int s = 0; s < SRC_COUNT; s++) begin
			idx[s] = dst_idx_t'($urandom);
			dat[s] = xb_data_t'($urandom);
		end
		drive_cycle(src_mask_t'($urandom), idx, dat, en);
	endtask

	// empty the pipe so every word of a test is checked inside it
	task automatic drain();
		repeat (4) drive_cycle('0, '0, '0, 1'b1);
	endtask

	task automatic wb_access(input logic we, input wb_adr_t adr, output wb_dat_t data);
		int waited;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = we ? wb_dat_t'($urandom) : '0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < 8);
		if (!wb_ack) begin
			abort_run($sformatf("wishbone ack never came for offset %0d", adr));
		end
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic check_counters(input logic expect_zero);
		wb_dat_t rd;
		for (int d = 0; d < DST_COUNT; d++) begin
			wb_access(1'b0, wb_adr_t'(REG_DELIV_BASE + d), rd);
			check_count($sformatf("delivered[%0d]", d), expect_zero ? '0 : model_deliv[d], rd);
		end
		wb_access(1'b0, REG_OFFERED, rd);
		check_count("offered", expect_zero ? '0 : model_offered, rd);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		dst_idx_t [SRC_COUNT-1:0] idx;
		xb_data_t [SRC_COUNT-1:0] dat;
		src_mask_t                v;
		wb_dat_t                  rd;
		int                       s;
		int                       wait_cnt;
		int                       stall_left;

		cke = 1'b0;
		in_valid = '0;
		in_dst_index = '0;
		in_data = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		error_total = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(22845));

		wait_cnt = 0;
		while (arst_n !== 1'b1 && wait_cnt < 10) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (arst_n !== 1'b1) begin
			abort_run("reset was never released");
		end

		start_test("reset");
		@(negedge clk);
		check_valid('0, out_valid);
		if (wb_ack !== 1'b0) begin
			$display("wb_ack is high after reset in test %s", test_name);
			note_error();
		end
		check_counters(1'b1);
		finish_test();

		start_test("single_routes");
		for (int d = 0; d < DST_COUNT; d++) begin
			s = int'($urandom % SRC_COUNT);
			for (int k = 0; k < SRC_COUNT; k++) begin
				idx[k] = dst_idx_t'($urandom);
				dat[k] = xb_data_t'($urandom);
			end
			idx[s] = dst_idx_t'(d);
			drive_cycle(src_mask_t'(1 << s), idx, dat, 1'b1);
			drive_cycle('0, '0, '0, 1'b1);
		end
		drain();
		finish_test();

		start_test("collisions");
		for (int k = 0; k < 8; k++) begin
			v = src_mask_t'($urandom);
			v[k % SRC_COUNT] = 1'b1;
			v[(k + 1) % SRC_COUNT] = 1'b1;
			for (int j = 0; j < SRC_COUNT; j++) begin
				idx[j] = dst_idx_t'(k % DST_COUNT);
				dat[j] = xb_data_t'($urandom);
			end
			drive_cycle(v, idx, dat, 1'b1);
		end
		drain();
		finish_test();

		start_test("random_traffic");
		repeat (200) random_cycle(1'b1);
		drain();
		finish_test();

		// stretches of low cke inside the traffic
		start_test("stall");
		stall_left = 0;
		repeat (200) begin
			if (stall_left == 0 && ($urandom % 8) == 0) begin
				stall_left = 1 + int'($urandom % 6);
			end
			random_cycle(stall_left == 0);
			if (stall_left > 0) begin
				stall_left--;
			end
		end
		drain();
		finish_test();

		start_test("statistics");
		drive_cycle('0, '0, '0, 1'b0);
		check_counters(1'b0);
		wb_access(1'b1, REG_CLEAR, rd);
		check_counters(1'b1);
		finish_test();

		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, error_total);
		if (error_total == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	// period of 4
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset low for 3 cycles, released away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

/* src/xbar_top.sv */
module xbar_top #(
	parameter bit STAGE0_REG = 1'b1,
	parameter bit STAGE1_REG = 1'b1,
	parameter bit STAGE2_REG = 1'b1
) (
	input  logic                                            clk,
	input  logic                                            arst_n,
	input  logic                                            cke,
	input  logic [xbar_pkg::SRC_COUNT-1:0]                  in_valid,
	input  xbar_pkg::dst_idx_t [xbar_pkg::SRC_COUNT-1:0]    in_dst_index,
	input  xbar_pkg::xb_data_t [xbar_pkg::SRC_COUNT-1:0]    in_data,
	output logic [xbar_pkg::DST_COUNT-1:0]                  out_valid,
	output xbar_pkg::src_idx_t [xbar_pkg::DST_COUNT-1:0]    out_src_index,
	output xbar_pkg::xb_data_t [xbar_pkg::DST_COUNT-1:0]    out_data,
	input  logic                                            wb_cyc,
	input  logic                                            wb_stb,
	input  logic                                            wb_we,
	input  xbar_pkg::wb_adr_t                               wb_adr,
	input  xbar_pkg::wb_dat_t                               wb_dat_w,
	output xbar_pkg::wb_dat_t                               wb_dat_r,
	output logic                                            wb_ack
);

	// one enable freezes the whole pipe
	crossbar #(
		.STAGE0_REG (STAGE0_REG),
		.STAGE1_REG (STAGE1_REG),
		.STAGE2_REG (STAGE2_REG)
	) crossbar_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.cke0          (cke),
		.cke1          (cke),
		.cke2          (cke),
		.in_valid      (in_valid),
		.in_dst_index  (in_dst_index),
		.in_data       (in_data),
		.out_valid     (out_valid),
		.out_src_index (out_src_index),
		.out_data      (out_data)
	);

	// stats watch both ends of the crossbar
	xbar_stats_wb stats_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.cke       (cke),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack)
	);

endmodule

/* src/xbar_stats_wb.sv */
module xbar_stats_wb (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            cke,
	input  logic [xbar_pkg::SRC_COUNT-1:0]  in_valid,
	input  logic [xbar_pkg::DST_COUNT-1:0]  out_valid,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  xbar_pkg::wb_adr_t               wb_adr,
	input  xbar_pkg::wb_dat_t               wb_dat_w,
	output xbar_pkg::wb_dat_t               wb_dat_r,
	output logic                            wb_ack
);

	import xbar_pkg::*;

	cnt_t    deliv_cnt [DST_COUNT];
	cnt_t    offered_cnt;
	cnt_t    offered_inc;
	wb_dat_t rd_data;
	logic    wb_req;
	logic    clear;

	// --------------------------------------------------
	// bus decode
	// --------------------------------------------------
	// new request only while ack is low, so each access acks once
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	// write data is don't care, the access itself clears
	assign clear = wb_req && wb_we && (wb_adr == REG_CLEAR);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_req;
		end
	end

	always_comb begin
		rd_data = '0;
		for (int d = 0; d < DST_COUNT; d++) begin
			if (wb_adr == wb_adr_t'(REG_DELIV_BASE + d)) begin
				rd_data = deliv_cnt[d];
			end
		end
		if (wb_adr == REG_OFFERED) begin
			rd_data = offered_cnt;
		end
	end

	// read data held for the ack cycle
	always_ff @(posedge clk) begin
		if (wb_req && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

	// --------------------------------------------------
	// counters
	// --------------------------------------------------
	assign offered_inc = cnt_t'($countones(in_valid));

	// clear beats any increment in the same cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			offered_cnt <= '0;
			for (int d = 0; d < DST_COUNT; d++) begin
				deliv_cnt[d] <= '0;
			end
		end else if (clear) begin
			offered_cnt <= '0;
			for (int d = 0; d < DST_COUNT; d++) begin
				deliv_cnt[d] <= '0;
			end
		end else if (cke) begin
			offered_cnt <= offered_cnt + offered_inc;
			for (int d = 0; d < DST_COUNT; d++) begin
				if (out_valid[d]) begin
					deliv_cnt[d] <= deliv_cnt[d] + 1'b1;
				end
			end
		end
	end

	// direction and address known whenever a request is up
	a_req_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		(wb_cyc && wb_stb) |-> !$isunknown({wb_we, wb_adr})
	);

endmodule

/* src/crossbar.sv */
module crossbar #(
	parameter bit STAGE0_REG = 1'b1,
	parameter bit STAGE1_REG = 1'b1,
	parameter bit STAGE2_REG = 1'b1
) (
	input  logic                                            clk,
	input  logic                                            arst_n,
	input  logic                                            cke0,
	input  logic                                            cke1,
	input  logic                                            cke2,
	input  logic [xbar_pkg::SRC_COUNT-1:0]                  in_valid,
	input  xbar_pkg::dst_idx_t [xbar_pkg::SRC_COUNT-1:0]    in_dst_index,
	input  xbar_pkg::xb_data_t [xbar_pkg::SRC_COUNT-1:0]    in_data,
	output logic [xbar_pkg::DST_COUNT-1:0]                  out_valid,
	output xbar_pkg::src_idx_t [xbar_pkg::DST_COUNT-1:0]    out_src_index,
	output xbar_pkg::xb_data_t [xbar_pkg::DST_COUNT-1:0]    out_data
);

	import xbar_pkg::*;

	localparam int S0_WIDTH = SRC_COUNT * (1 + DST_IDX_WIDTH + DATA_WIDTH);
	localparam int S1_WIDTH = DST_COUNT * SRC_COUNT + SRC_COUNT * DATA_WIDTH;
	localparam int S2_WIDTH = DST_COUNT * (1 + SRC_IDX_WIDTH + DATA_WIDTH);

	// --------------------------------------------------
	// stage 0, input register
	// --------------------------------------------------
	logic [S0_WIDTH-1:0]           stage0_q;
	logic [SRC_COUNT-1:0]          s0_valid;
	dst_idx_t [SRC_COUNT-1:0]      s0_dst_index;
	xb_data_t [SRC_COUNT-1:0]      s0_data;

	pipeline_ff #(
		.WIDTH (S0_WIDTH),
		.REG   (STAGE0_REG),
		.INIT  ('0)
	) stage0_ff (
		.clk      (clk),
		.arst_n   (arst_n),
		.cke      (cke0),
		.in_data  ({in_valid, in_dst_index, in_data}),
		.out_data (stage0_q)
	);

	assign {s0_valid, s0_dst_index, s0_data} = stage0_q;

	// --------------------------------------------------
	// stage 1, request map and data
	// --------------------------------------------------
	req_map_t                      s1_req_map_d;
	logic [S1_WIDTH-1:0]           stage1_q;
	req_map_t                      s1_req_map;
	xb_data_t [SRC_COUNT-1:0]      s1_data;

	xbar_route_decode route_decode (
		.valid     (s0_valid),
		.dst_index (s0_dst_index),
		.req_map   (s1_req_map_d)
	);

	pipeline_ff #(
		.WIDTH (S1_WIDTH),
		.REG   (STAGE1_REG),
		.INIT  ('0)
	) stage1_ff (
		.clk      (clk),
		.arst_n   (arst_n),
		.cke      (cke1),
		.in_data  ({s1_req_map_d, s0_data}),
		.out_data (stage1_q)
	);

	assign {s1_req_map, s1_data} = stage1_q;

	// --------------------------------------------------
	// stage 2, granted lanes
	// --------------------------------------------------
	logic [DST_COUNT-1:0]          s2_valid_d;
	src_idx_t [DST_COUNT-1:0]      s2_src_index_d;
	xb_data_t [DST_COUNT-1:0]      s2_data_d;
	logic [S2_WIDTH-1:0]           stage2_q;

	xbar_priority_select priority_select (
		.req_map       (s1_req_map),
		.data          (s1_data),
		.out_valid     (s2_valid_d),
		.out_src_index (s2_src_index_d),
		.out_data      (s2_data_d)
	);

	pipeline_ff #(
		.WIDTH (S2_WIDTH),
		.REG   (STAGE2_REG),
		.INIT  ('0)
	) stage2_ff (
		.clk      (clk),
		.arst_n   (arst_n),
		.cke      (cke2),
		.in_data  ({s2_valid_d, s2_src_index_d, s2_data_d}),
		.out_data (stage2_q)
	);

	assign {out_valid, out_src_index, out_data} = stage2_q;

endmodule

/* src/xbar_priority_select.sv */
module xbar_priority_select (
	input  xbar_pkg::req_map_t                              req_map,
	input  xbar_pkg::xb_data_t [xbar_pkg::SRC_COUNT-1:0]    data,
	output logic [xbar_pkg::DST_COUNT-1:0]                  out_valid,
	output xbar_pkg::src_idx_t [xbar_pkg::DST_COUNT-1:0]    out_src_index,
	output xbar_pkg::xb_data_t [xbar_pkg::DST_COUNT-1:0]    out_data
);

	import xbar_pkg::*;

	always_comb begin
		logic [SRC_COUNT-1:0] row;

		out_valid     = '0;
		out_src_index = '0;
		out_data      = '0;

		for (int d = 0; d < DST_COUNT; d++) begin
			row = req_map[d*SRC_COUNT +: SRC_COUNT];

			// walk down so the lowest requester is written last and wins
			for (int s = SRC_COUNT - 1; s >= 0; s--) begin
				if (row[s]) begin
					out_valid[d]     = 1'b1;
					out_src_index[d] = src_idx_t'(s);
					out_data[d]      = data[s];
				end
			end
		end
	end

endmodule

/* src/xbar_route_decode.sv */
module xbar_route_decode (
	input  logic [xbar_pkg::SRC_COUNT-1:0]                  valid,
	input  xbar_pkg::dst_idx_t [xbar_pkg::SRC_COUNT-1:0]    dst_index,
	output xbar_pkg::req_map_t                              req_map
);

	import xbar_pkg::*;

	always_comb begin
		// one row per destination, one bit per source
		for (int d = 0; d < DST_COUNT; d++) begin
			for (int s = 0; s < SRC_COUNT; s++) begin
				req_map[d*SRC_COUNT + s] = valid[s] && (dst_index[s] == dst_idx_t'(d));
			end
		end
	end

endmodule

/* src/pipeline_ff.sv */
module pipeline_ff #(
	parameter int               WIDTH = 1,
	parameter bit               REG   = 1'b1,
	parameter logic [WIDTH-1:0] INIT  = '0
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cke,
	input  logic [WIDTH-1:0] in_data,
	output logic [WIDTH-1:0] out_data
);

	generate
		if (REG) begin : g_reg
			logic [WIDTH-1:0] data_q;

			// load only while the stage is enabled
			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					data_q <= INIT;
				end else if (cke) begin
					data_q <= in_data;
				end
			end

			assign out_data = data_q;
		end else begin : g_bypass
			// stage removed, zero latency
			assign out_data = in_data;
		end
	endgenerate

	// stage output must be fully known once out of reset
	a_no_x_out: assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_data)
	);

endmodule

/* src/xbar_pkg.sv */
package xbar_pkg;

	// --------------------------------------------------
	// crossbar sizes
	// --------------------------------------------------
	localparam int SRC_COUNT     = 4;
	localparam int DST_COUNT     = 4;
	localparam int DATA_WIDTH    = 16;
	localparam int SRC_IDX_WIDTH = $clog2(SRC_COUNT);
	localparam int DST_IDX_WIDTH = $clog2(DST_COUNT);

	// one lane of each kind
	typedef logic [DATA_WIDTH-1:0]    xb_data_t;
	typedef logic [SRC_IDX_WIDTH-1:0] src_idx_t;
	typedef logic [DST_IDX_WIDTH-1:0] dst_idx_t;

	// bit d*SRC_COUNT+s set when source s wants destination d
	typedef logic [DST_COUNT*SRC_COUNT-1:0] req_map_t;

	// --------------------------------------------------
	// wishbone and statistics
	// --------------------------------------------------
	localparam int WB_ADR_WIDTH = 4;
	localparam int WB_DAT_WIDTH = 32;
	localparam int CNT_WIDTH    = 32;

	typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;
	typedef logic [CNT_WIDTH-1:0]    cnt_t;

	// word offsets, delivered counters sit at base + destination
	localparam wb_adr_t REG_DELIV_BASE = 4'd0;
	localparam wb_adr_t REG_OFFERED    = 4'd4;
	localparam wb_adr_t REG_CLEAR      = 4'd8;

endpackage
